// ==== Bender.yml ====
package:
  name: sort_xcel

sources:
  - design/sort_pkg.sv
  - design/sort_xcel_regs.sv
  - design/sort_mem_seq.sv
  - design/sort_merge_unit.sv
  - design/sort_xcel_top.sv
  - target: test
    files:
      - tb/sort_xcel_sva.sv
      - tb/sort_xcel_tb.sv

// ==== design/sort_mem_seq.sv ====
// Load/store sequencer. Streams the array into the element buffer, starts
// the merge unit, then writes the sorted words back one request at a time.
`timescale 1ns/100ps

module sort_mem_seq import sort_pkg::*; (
  input  logic              clk,
  input  logic              reset,

  input  logic              go,
  input  job_cfg_t          job_cfg,
  output logic              job_done,

  output mem_req_t          mem_req,
  output logic              mem_req_val,
  input  logic              mem_req_rdy,

  input  mem_resp_t         mem_resp,
  input  logic              mem_resp_val,
  output logic              mem_resp_rdy,

  output buf_wr_t           buf_wr,
  output logic              sort_start,
  input  logic              sort_done,
  output logic [IDX_W-1:0]  rd_idx,
  input  logic [DATA_W-1:0] rd_data
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LD_REQ,
    S_LD_RESP,
    S_SORT,
    S_ST_REQ,
    S_ST_RESP,
    S_FINISH
  } phase_e;

  phase_e           phase;
  logic [CNT_W-1:0] idx;
  logic [CNT_W-1:0] idx_inc;
  logic             last;
  logic             empty;

  assign idx_inc = idx + CNT_W'(1);
  assign last    = (idx_inc == job_cfg.count);
  assign empty   = (job_cfg.count == '0);

  // --------------------------------------------------------------------------
  // Memory streams
  // --------------------------------------------------------------------------

  // Word address is base + 4 * index
  assign mem_req.addr = job_cfg.base + {{(ADDR_W-CNT_W-2){1'b0}}, idx, 2'b00};
  assign mem_req.op   = (phase == S_ST_REQ) ? MEM_WR : MEM_RD;
  assign mem_req.data = rd_data;
  assign mem_req_val  = (phase == S_LD_REQ) | (phase == S_ST_REQ);

  // Ready only while a response is awaited
  assign mem_resp_rdy = (phase == S_LD_RESP) | (phase == S_ST_RESP);

  // Load data goes straight into the buffer
  assign buf_wr.en   = (phase == S_LD_RESP) & mem_resp_val;
  assign buf_wr.idx  = idx[IDX_W-1:0];
  assign buf_wr.data = mem_resp.data;
  assign rd_idx      = idx[IDX_W-1:0];

  // Pulse on entry to the sort phase
  assign sort_start = ((phase == S_LD_RESP) & mem_resp_val & last) |
                      ((phase == S_IDLE) & go & empty);

  assign job_done = (phase == S_FINISH);

  // --------------------------------------------------------------------------
  // Phase FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= S_IDLE;
      idx   <= '0;
    end else begin
      case (phase)
        S_IDLE: if (go) begin
          idx   <= '0;
          // Empty job skips loading entirely
          phase <= empty ? S_SORT : S_LD_REQ;
        end
        S_LD_REQ:  if (mem_req_rdy) phase <= S_LD_RESP;
        S_LD_RESP: if (mem_resp_val) begin
          idx   <= idx_inc;
          phase <= last ? S_SORT : S_LD_REQ;
        end
        S_SORT: if (sort_done) begin
          idx   <= '0;
          phase <= empty ? S_FINISH : S_ST_REQ;
        end
        S_ST_REQ:  if (mem_req_rdy) phase <= S_ST_RESP;
        // Finish right after the last write response
        S_ST_RESP: if (mem_resp_val) begin
          idx   <= idx_inc;
          phase <= last ? S_FINISH : S_ST_REQ;
        end
        default: phase <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== design/sort_merge_unit.sv ====
// Element and scratch buffers with a bottom-up merge sort engine. Each
// pass merges run pairs into scratch, copies back, then doubles the width.
`timescale 1ns/100ps

module sort_merge_unit import sort_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              sort_start,
  input  logic [CNT_W-1:0]  count,
  input  buf_wr_t           buf_wr,
  input  logic [IDX_W-1:0]  rd_idx,
  output logic [DATA_W-1:0] rd_data,
  output logic              sort_done
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_PASS_SETUP,
    M_MERGE,
    M_MERGE_FIN,
    M_COPY,
    M_WIDTH_STEP
  } state_e;

  state_e            state;
  logic [DATA_W-1:0] elem    [MAX_ELEMS];
  logic [DATA_W-1:0] scratch [MAX_ELEMS];

  // Merge width, pair start, run cursors and ends, output and copy index
  logic [CNT_W-1:0]  width;
  logic [CNT_W-1:0]  start;
  logic [CNT_W-1:0]  li, le, ri, re, oi, cp;

  logic [CNT_W-1:0]  width_x2;
  logic [CNT_W-1:0]  mid_raw, end_raw;
  logic [DATA_W-1:0] left_head, right_head;
  logic              left_ok, right_ok, take_left;

  assign width_x2 = {width[CNT_W-2:0], 1'b0};
  assign mid_raw  = start + width;
  assign end_raw  = start + width_x2;

  // --------------------------------------------------------------------------
  // Merge datapath
  // --------------------------------------------------------------------------

  assign left_head  = elem[li[IDX_W-1:0]];
  assign right_head = elem[ri[IDX_W-1:0]];
  assign left_ok    = (li < le);
  assign right_ok   = (ri < re);
  // Ties go left, keeps the sort stable
  assign take_left  = left_ok & (~right_ok | (left_head <= right_head));

  assign rd_data = elem[rd_idx];

  // Copy-back owns the buffer during a pass, loads own it otherwise
  always_ff @(posedge clk) begin
    if (state == M_COPY) begin
      elem[cp[IDX_W-1:0]] <= scratch[cp[IDX_W-1:0]];
    end else if (buf_wr.en) begin
      elem[buf_wr.idx] <= buf_wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (state == M_MERGE && (left_ok || right_ok)) begin
      scratch[oi[IDX_W-1:0]] <= take_left ? left_head : right_head;
    end
  end

  // --------------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= M_IDLE;
      sort_done <= 1'b0;
      width     <= '0;
      start     <= '0;
      li        <= '0;
      le        <= '0;
      ri        <= '0;
      re        <= '0;
      oi        <= '0;
      cp        <= '0;
    end else begin
      sort_done <= 1'b0;
      case (state)
        M_IDLE: if (sort_start) begin
          width <= CNT_W'(1);
          start <= '0;
          // Zero or one element is already sorted
          if (count <= CNT_W'(1)) begin
            sort_done <= 1'b1;
          end else begin
            state <= M_PASS_SETUP;
          end
        end
        // Bound both runs of the pair by the count
        M_PASS_SETUP: begin
          li    <= start;
          le    <= (mid_raw < count) ? mid_raw : count;
          ri    <= (mid_raw < count) ? mid_raw : count;
          re    <= (end_raw < count) ? end_raw : count;
          oi    <= start;
          state <= M_MERGE;
        end
        M_MERGE: begin
          if (take_left) begin
            li <= li + CNT_W'(1);
            oi <= oi + CNT_W'(1);
          end else if (right_ok) begin
            ri <= ri + CNT_W'(1);
            oi <= oi + CNT_W'(1);
          end else begin
            state <= M_MERGE_FIN;
          end
        end
        M_MERGE_FIN: begin
          start <= end_raw;
          cp    <= '0;
          state <= (end_raw < count) ? M_PASS_SETUP : M_COPY;
        end
        M_COPY: begin
          cp <= cp + CNT_W'(1);
          if (cp + CNT_W'(1) == count) state <= M_WIDTH_STEP;
        end
        M_WIDTH_STEP: begin
          width <= width_x2;
          start <= '0;
          if (width_x2 >= count) begin
            sort_done <= 1'b1;
            state     <= M_IDLE;
          end else begin
            state <= M_PASS_SETUP;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

// ==== design/sort_pkg.sv ====
// Shared sizes, register indices, opcodes and stream messages for the
// merge-sort accelerator. Imported by every RTL module and the testbench.
package sort_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // One array element and one register word
  localparam int DATA_W    = 32;
  // Byte address width on the memory side
  localparam int ADDR_W    = 32;
  // Element buffer depth; longer arrays are clamped to this
  localparam int MAX_ELEMS = 32;
  localparam int IDX_W     = 5;
  // Counts and merge widths, must hold MAX_ELEMS itself
  localparam int CNT_W     = 6;
  // Host register index field
  localparam int REG_IDX_W = 5;

  // --------------------------------------------------------------------------
  // Accelerator register map
  // --------------------------------------------------------------------------

  localparam logic [REG_IDX_W-1:0] REG_GO   = 5'd0;
  localparam logic [REG_IDX_W-1:0] REG_BASE = 5'd1;
  localparam logic [REG_IDX_W-1:0] REG_SIZE = 5'd2;

  // --------------------------------------------------------------------------
  // Opcodes
  // --------------------------------------------------------------------------

  typedef enum logic {
    XCEL_RD = 1'b0,
    XCEL_WR = 1'b1
  } xcel_op_e;

  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  // --------------------------------------------------------------------------
  // Stream messages
  // --------------------------------------------------------------------------

  // Host to accelerator, 38 bits
  typedef struct packed {
    xcel_op_e               op;
    logic [REG_IDX_W-1:0]   addr;
    logic [DATA_W-1:0]      data;
  } xcel_req_t;

  // Accelerator to host, 33 bits
  typedef struct packed {
    xcel_op_e               op;
    logic [DATA_W-1:0]      data;
  } xcel_resp_t;

  // Accelerator to memory, byte addressed, 65 bits
  typedef struct packed {
    mem_op_e                op;
    logic [ADDR_W-1:0]      addr;
    logic [DATA_W-1:0]      data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e                op;
    logic [DATA_W-1:0]      data;
  } mem_resp_t;

  // --------------------------------------------------------------------------
  // Internal stage links
  // --------------------------------------------------------------------------

  // Load write port into the element buffer
  typedef struct packed {
    logic                   en;
    logic [IDX_W-1:0]       idx;
    logic [DATA_W-1:0]      data;
  } buf_wr_t;

  // Job setup held by the front end for the whole job
  typedef struct packed {
    logic [ADDR_W-1:0]      base;
    logic [CNT_W-1:0]       count;
  } job_cfg_t;

endpackage

// ==== design/sort_xcel_regs.sv ====
// Host register front end. Holds base, clamped size and busy, answers
// every accepted request in the same cycle and launches the job on go.
`timescale 1ns/100ps

module sort_xcel_regs import sort_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  xcel_req_t  xcel_req,
  input  logic       xcel_req_val,
  output logic       xcel_req_rdy,

  output xcel_resp_t xcel_resp,
  output logic       xcel_resp_val,
  input  logic       xcel_resp_rdy,

  output logic       go,
  output job_cfg_t   job_cfg,
  input  logic       job_done
);

  logic              busy;
  logic [ADDR_W-1:0] base;
  logic [CNT_W-1:0]  count;
  logic              xfer;
  logic              is_wr;
  logic [CNT_W-1:0]  size_clamped;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Idle: valid and ready pass straight through, zero latency
  assign xcel_resp_val = xcel_req_val & ~busy;
  assign xcel_req_rdy  = xcel_resp_rdy & ~busy;
  assign xfer          = xcel_req_val & xcel_req_rdy;
  assign is_wr         = (xcel_req.op == XCEL_WR);

  // Reads always see 1, meaning done once the busy wait is over
  assign xcel_resp.op   = xcel_req.op;
  assign xcel_resp.data = is_wr ? DATA_W'(0) : DATA_W'(1);

  assign go = xfer & is_wr & (xcel_req.addr == REG_GO);

  // Anything past the buffer depth is left alone in memory
  assign size_clamped = (xcel_req.data > DATA_W'(MAX_ELEMS)) ? CNT_W'(MAX_ELEMS)
                                                             : xcel_req.data[CNT_W-1:0];

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (go) begin
      busy <= 1'b1;
    end else if (job_done) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && is_wr && xcel_req.addr == REG_BASE) begin
      base <= xcel_req.data;
    end
  end

  // Count starts at zero so a bare go is an empty job
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (xfer && is_wr && xcel_req.addr == REG_SIZE) begin
      count <= size_clamped;
    end
  end

  // Stable for the whole job since no request is taken while busy
  assign job_cfg.base  = base;
  assign job_cfg.count = count;

endmodule

// ==== design/sort_xcel_top.sv ====
// Merge-sort accelerator top level. Chains the register front end, the
// load/store sequencer and the merge unit between host and memory streams.
`timescale 1ns/100ps

module sort_xcel_top import sort_pkg::*; (
  input  logic       clk,
  input  logic       reset,

  input  xcel_req_t  xcel_req,
  input  logic       xcel_req_val,
  output logic       xcel_req_rdy,
  output xcel_resp_t xcel_resp,
  output logic       xcel_resp_val,
  input  logic       xcel_resp_rdy,

  output mem_req_t   mem_req,
  output logic       mem_req_val,
  input  logic       mem_req_rdy,
  input  mem_resp_t  mem_resp,
  input  logic       mem_resp_val,
  output logic       mem_resp_rdy
);

  // Front end to sequencer
  logic              go;
  logic              job_done;
  job_cfg_t          job_cfg;

  // Sequencer to merge unit
  buf_wr_t           buf_wr;
  logic              sort_start;
  logic              sort_done;
  logic [IDX_W-1:0]  rd_idx;
  logic [DATA_W-1:0] rd_data;

  sort_xcel_regs sort_xcel_regs_inst (
    .clk           (clk),
    .reset         (reset),
    .xcel_req      (xcel_req),
    .xcel_req_val  (xcel_req_val),
    .xcel_req_rdy  (xcel_req_rdy),
    .xcel_resp     (xcel_resp),
    .xcel_resp_val (xcel_resp_val),
    .xcel_resp_rdy (xcel_resp_rdy),
    .go            (go),
    .job_cfg       (job_cfg),
    .job_done      (job_done)
  );

  sort_mem_seq sort_mem_seq_inst (
    .clk           (clk),
    .reset         (reset),
    .go            (go),
    .job_cfg       (job_cfg),
    .job_done      (job_done),
    .mem_req       (mem_req),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp      (mem_resp),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .buf_wr        (buf_wr),
    .sort_start    (sort_start),
    .sort_done     (sort_done),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  // Count for the merge passes is the clamped job size
  sort_merge_unit sort_merge_unit_inst (
    .clk           (clk),
    .reset         (reset),
    .sort_start    (sort_start),
    .count         (job_cfg.count),
    .buf_wr        (buf_wr),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .sort_done     (sort_done)
  );

endmodule

// ==== tb/sort_xcel_sva.sv ====
// Stream protocol checks for the merge-sort accelerator, bound into the top
// level so the properties see go, job_done and the job setup.
`timescale 1ns/100ps

module sort_xcel_sva import sort_pkg::*; (
  input logic       clk,
  input logic       reset,
  input mem_req_t   mem_req,
  input logic       mem_req_val,
  input logic       mem_req_rdy,
  input logic       mem_resp_val,
  input logic       mem_resp_rdy,
  input xcel_resp_t xcel_resp,
  input logic       xcel_resp_val,
  input logic       xcel_resp_rdy,
  input logic       xcel_req_rdy,
  input logic       go,
  input logic       job_done,
  input job_cfg_t   job_cfg
);

  // Count of failed properties
  int                violations;
  logic              busy;
  logic              pending;
  logic              store_seen;
  logic [ADDR_W-1:0] last_addr;

  initial violations = 0;

  // Address of the last element of the job
  assign last_addr = job_cfg.base + ((ADDR_W'(job_cfg.count) - ADDR_W'(1)) << 2);

  // Shadow state for job busy, request outstanding and store phase reached
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      pending    <= 1'b0;
      store_seen <= 1'b0;
    end else begin
      if (go) busy <= 1'b1;
      else if (job_done) busy <= 1'b0;
      if (mem_req_val && mem_req_rdy) pending <= 1'b1;
      else if (mem_resp_val && mem_resp_rdy) pending <= 1'b0;
      if (go) store_seen <= 1'b0;
      else if (mem_req_val && mem_req.op == MEM_WR) store_seen <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Properties
  // --------------------------------------------------------------------------

  a_req_in_range: assert property (@(posedge clk) disable iff (reset)
    mem_req_val |-> (mem_req.addr[1:0] == 2'b00) && (mem_req.addr >= job_cfg.base) &&
                    (mem_req.addr <= last_addr))
    else begin
      $error("memory request misaligned or outside the array");
      violations++;
    end

  a_mem_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
    else begin
      $error("memory request changed while stalled");
      violations++;
    end

  a_host_resp_stable: assert property (@(posedge clk) disable iff (reset)
    xcel_resp_val && !xcel_resp_rdy |=> xcel_resp_val && $stable(xcel_resp))
    else begin
      $error("host response changed while stalled");
      violations++;
    end

  // Loads all come before the first store of a job
  a_no_load_after_store: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && store_seen |-> mem_req.op == MEM_WR)
    else begin
      $error("load request issued after a store in the same job");
      violations++;
    end

  a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_req_val |-> !pending)
    else begin
      $error("second memory request while one is outstanding");
      violations++;
    end

  a_resp_rdy_pending: assert property (@(posedge clk) disable iff (reset)
    !pending |-> !mem_resp_rdy)
    else begin
      $error("memory response ready with no request pending");
      violations++;
    end

  a_busy_blocks_host: assert property (@(posedge clk) disable iff (reset)
    busy |-> !xcel_req_rdy)
    else begin
      $error("host request accepted while busy");
      violations++;
    end

endmodule

bind sort_xcel_top sort_xcel_sva sort_xcel_sva_inst (
  .clk           (clk),
  .reset         (reset),
  .mem_req       (mem_req),
  .mem_req_val   (mem_req_val),
  .mem_req_rdy   (mem_req_rdy),
  .mem_resp_val  (mem_resp_val),
  .mem_resp_rdy  (mem_resp_rdy),
  .xcel_resp     (xcel_resp),
  .xcel_resp_val (xcel_resp_val),
  .xcel_resp_rdy (xcel_resp_rdy),
  .xcel_req_rdy  (xcel_req_rdy),
  .go            (go),
  .job_done      (job_done),
  .job_cfg       (job_cfg)
);

// ==== tb/sort_xcel_tb.sv ====
// Testbench for the merge-sort accelerator. Models a stalling memory, programs
// the host registers for each test and checks the sorted array in memory.
`timescale 1ns/100ps

module sort_xcel_tb import sort_pkg::*; ();

  typedef enum int {
    FILL_RANDOM,
    FILL_DUPS,
    FILL_EQUAL,
    FILL_REVERSED
  } fill_e;

  // Word-addressed memory model of 1 KiB
  localparam int MEM_WORDS       = 256;
  localparam int NUM_TESTS       = 8;
  // Sum of all test lengths below
  localparam int TOTAL_ELEMS     = 1 + 2 + 7 + 32 + 32 + 7 + 32 + 40;
  localparam int WATCHDOG_CYCLES = 400 * TOTAL_ELEMS + 100 * NUM_TESTS;

  logic       clk;
  logic       reset;
  xcel_req_t  xcel_req;
  logic       xcel_req_val;
  logic       xcel_req_rdy;
  xcel_resp_t xcel_resp;
  logic       xcel_resp_val;
  logic       xcel_resp_rdy;
  mem_req_t   mem_req;
  logic       mem_req_val;
  logic       mem_req_rdy;
  mem_resp_t  mem_resp;
  logic       mem_resp_val;
  logic       mem_resp_rdy;

  logic [DATA_W-1:0] mem       [0:MEM_WORDS-1];
  logic [DATA_W-1:0] ref_words [0:MAX_ELEMS-1];
  // Write responses seen by the memory model in the current job
  int                store_count;

  sort_xcel_top sort_xcel_top_inst (
    .clk           (clk),
    .reset         (reset),
    .xcel_req      (xcel_req),
    .xcel_req_val  (xcel_req_val),
    .xcel_req_rdy  (xcel_req_rdy),
    .xcel_resp     (xcel_resp),
    .xcel_resp_val (xcel_resp_val),
    .xcel_resp_rdy (xcel_resp_rdy),
    .mem_req       (mem_req),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp      (mem_resp),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------------------------------------------------------------
  // Checking helpers
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // Ascending unsigned insertion sort of the host copy
  task automatic sort_reference(input int cnt);
    logic [DATA_W-1:0] key;
    int                j;
    for (int i = 1; i < cnt; i++) begin
      key = ref_words[i];
      j   = i - 1;
      while (j >= 0 && ref_words[j] > key) begin
        ref_words[j + 1] = ref_words[j];
        j--;
      end
      ref_words[j + 1] = key;
    end
  endtask

  // Stop at the first failed protocol property
  always @(sort_xcel_top_inst.sort_xcel_sva_inst.violations) begin
    if (sort_xcel_top_inst.sort_xcel_sva_inst.violations != 0) begin
      $display("A protocol assertion on the host or memory stream failed");
      $display("*** FAILED ***");
      $fatal(1, "protocol violation");
    end
  end

  // --------------------------------------------------------------------------
  // Memory model
  // --------------------------------------------------------------------------

  // Random request stalls and 0 to 3 cycles before each response
  initial begin : memory_model
    mem_req_t  req;
    mem_resp_t rsp;
    logic      took;
    logic      done;
    int        delay;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    forever begin
      @(negedge clk);
      took = (mem_req_val === 1'b1) && mem_req_rdy;
      if (took) req = mem_req;
      @(posedge clk);
      if (!took) begin
        mem_req_rdy <= ($urandom % 4) != 0;
      end else begin
        mem_req_rdy <= 1'b0;
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        rsp.op = req.op;
        if (req.op == MEM_WR) begin
          mem[req.addr[9:2]] = req.data;
          rsp.data = '0;
        end else begin
          rsp.data = mem[req.addr[9:2]];
        end
        mem_resp     <= rsp;
        mem_resp_val <= 1'b1;
        done = 1'b0;
        while (!done) begin
          @(negedge clk);
          done = mem_resp_rdy;
          if (done && req.op == MEM_WR) store_count++;
          @(posedge clk);
        end
        mem_resp_val <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Host side
  // --------------------------------------------------------------------------

  // One register access with random back-pressure on the response
  task automatic host_access(input xcel_op_e op, input logic [REG_IDX_W-1:0] addr,
                             input logic [DATA_W-1:0] data, output xcel_resp_t resp);
    xcel_req_t req;
    logic      done;
    req.op   = op;
    req.addr = addr;
    req.data = data;
    done     = 1'b0;
    xcel_req      <= req;
    xcel_req_val  <= 1'b1;
    xcel_resp_rdy <= ($urandom % 4) != 0;
    while (!done) begin
      @(negedge clk);
      if (xcel_resp_val && xcel_resp_rdy) begin
        done = 1'b1;
        resp = xcel_resp;
      end
      @(posedge clk);
      if (!done) xcel_resp_rdy <= ($urandom % 4) != 0;
    end
    xcel_req_val  <= 1'b0;
    xcel_resp_rdy <= 1'b0;
  endtask

  task automatic check_write_resp(input string name, input xcel_resp_t resp);
    check_value({name, " op"}, DATA_W'(XCEL_WR), DATA_W'(resp.op));
    check_value({name, " data"}, '0, resp.data);
  endtask

  task automatic run_test(input string name, input int n, input fill_e fill);
    int                base_word;
    int                cnt;
    logic [DATA_W-1:0] same_val;
    logic [DATA_W-1:0] orig [0:MEM_WORDS-1];
    xcel_resp_t        resp;
    cnt       = (n > MAX_ELEMS) ? MAX_ELEMS : n;
    base_word = 8 + ($urandom % 64);
    same_val  = $urandom;
    for (int i = 0; i < n; i++) begin
      case (fill)
        FILL_DUPS:     mem[base_word + i] = $urandom % 4;
        FILL_EQUAL:    mem[base_word + i] = same_val;
        FILL_REVERSED: mem[base_word + i] = 32'hf000_0000 - DATA_W'(i) * 32'h1357;
        default:       mem[base_word + i] = $urandom;
      endcase
    end
    // Guard word before base through the word after the array
    for (int i = 0; i <= n + 1; i++) orig[i] = mem[base_word - 1 + i];
    for (int i = 0; i < cnt; i++) ref_words[i] = orig[i + 1];
    sort_reference(cnt);
    store_count = 0;

    host_access(XCEL_WR, REG_BASE, DATA_W'(base_word * 4), resp);
    check_write_resp({name, " base write"}, resp);
    host_access(XCEL_WR, REG_SIZE, DATA_W'(n), resp);
    check_write_resp({name, " size write"}, resp);
    host_access(XCEL_WR, REG_GO, '0, resp);
    check_write_resp({name, " go write"}, resp);
    // Blocks until the job is done
    host_access(XCEL_RD, REG_GO, '0, resp);
    check_value({name, " done op"}, DATA_W'(XCEL_RD), DATA_W'(resp.op));
    check_value({name, " done data"}, 32'd1, resp.data);
    check_value({name, " store responses"}, DATA_W'(cnt), DATA_W'(store_count));

    check_value({name, " word before base"}, orig[0], mem[base_word - 1]);
    for (int i = 0; i < cnt; i++) begin
      check_value($sformatf("%s sorted word %0d", name, i), ref_words[i], mem[base_word + i]);
    end
    // Clamped tail and the word after the array
    for (int i = cnt; i <= n; i++) begin
      check_value($sformatf("%s untouched word %0d", name, i), orig[i + 1], mem[base_word + i]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h2b54));
    reset         = 1'b1;
    xcel_req      = '0;
    xcel_req_val  = 1'b0;
    xcel_resp_rdy = 1'b0;
    store_count   = 0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h5a3c_0000 ^ (i * 32'h0101_0203);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    run_test("size1_random", 1, FILL_RANDOM);
    run_test("size2_random", 2, FILL_RANDOM);
    run_test("size7_random", 7, FILL_RANDOM);
    run_test("size32_random", 32, FILL_RANDOM);
    run_test("size32_dups", 32, FILL_DUPS);
    run_test("size7_all_equal", 7, FILL_EQUAL);
    run_test("size32_reversed", 32, FILL_REVERSED);
    run_test("size40_clamped", 40, FILL_RANDOM);

    @(posedge clk);
    // Protocol checker keeps its own count of failed properties
    if (sort_xcel_top_inst.sort_xcel_sva_inst.violations == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times",
               sort_xcel_top_inst.sort_xcel_sva_inst.violations);
      $display("*** FAILED ***");
      $fatal(1, "protocol violations");
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the sort never finished within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== vlog.f ====
design/sort_pkg.sv
design/sort_xcel_regs.sv
design/sort_mem_seq.sv
design/sort_merge_unit.sv
design/sort_xcel_top.sv
tb/sort_xcel_sva.sv
tb/sort_xcel_tb.sv
